// ==== verilog/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// Byte address and data word
`define ADDR_W 32
`define DATA_W 32

// Byte lanes of a word
`define LANE_W 8
`define NUM_LANES 4

// 1024 entries per bank, 4 KB per port
`define BANK_AW 10

`endif

// ==== verilog/mem_if_pkg.sv ====
`default_nettype none

`include "mem_consts.svh"

package mem_if_pkg;

  typedef logic [`ADDR_W-1:0] addr_t;
  typedef logic [`DATA_W-1:0] word_t;
  typedef logic [`LANE_W-1:0] lane_t;
  typedef logic [`NUM_LANES-1:0] lane_mask_t;
  typedef logic [$clog2(`NUM_LANES)-1:0] lane_sel_t;
  typedef logic [`BANK_AW-1:0] bank_addr_t;

  // Byte, halfword and word are one-hot
  typedef enum logic [2:0] {
    ST_LOAD = 3'b000,
    ST_BYTE = 3'b001,
    ST_HALF = 3'b010,
    ST_WORD = 3'b100
  } store_ctrl_t;

endpackage

`default_nettype wire

// ==== verilog/bank_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

interface bank_if import mem_if_pkg::*; ();

  // One entry per byte lane
  bank_addr_t bank_addr [`NUM_LANES];
  lane_t      wdata     [`NUM_LANES];
  lane_mask_t wen;
  logic       en;

  modport steer (
    output bank_addr,
    output wdata,
    output wen,
    output en
  );

  modport bank (
    input bank_addr,
    input wdata,
    input wen,
    input en
  );

endinterface

`default_nettype wire

// ==== verilog/lane_steer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module lane_steer import mem_if_pkg::*; (
  input  addr_t       addr,
  input  word_t       wdata,
  input  store_ctrl_t store,
  input  logic        accept,
  bank_if.steer       banks
);

  localparam int OFF_W = $clog2(`NUM_LANES);

  lane_sel_t  offset;
  bank_addr_t word_idx;
  bank_addr_t next_idx;
  lane_mask_t size_mask;
  logic [2*`NUM_LANES-1:0] mask_dbl;

  assign offset   = addr[OFF_W-1:0];
  assign word_idx = addr[OFF_W +: `BANK_AW];
  // Wraps at the top of the bank
  assign next_idx = word_idx + 1'b1;

  // Lanes touched by the store, before rotation
  always_comb begin
    case (store)
      ST_BYTE: size_mask = 4'b0001;
      ST_HALF: size_mask = 4'b0011;
      ST_WORD: size_mask = 4'b1111;
      default: size_mask = 4'b0000;
    endcase
  end

  // Rotate left by offset within the lane group
  assign mask_dbl = {size_mask, size_mask} << offset;

  assign banks.wen = accept ? mask_dbl[2*`NUM_LANES-1:`NUM_LANES] : '0;
  assign banks.en  = accept;

  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
    localparam lane_sel_t LANE_ID = lane_sel_t'(i);

    lane_sel_t src_byte;

    // Data byte that lands on this lane
    assign src_byte = LANE_ID - offset;

    // Lanes below the start belong to the next word
    assign banks.bank_addr[i] = (LANE_ID < offset) ? next_idx : word_idx;
    assign banks.wdata[i]     = wdata[src_byte*`LANE_W +: `LANE_W];
  end

endmodule

`default_nettype wire

// ==== verilog/byte_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module byte_bank import mem_if_pkg::*; #(
  parameter int DEPTH_LOG2 = `BANK_AW
) (
  input  logic       clk_1,
  input  logic       en,
  input  logic       wen,
  input  bank_addr_t bank_addr,
  input  lane_t      wdata,
  output lane_t      rdata
);

  logic [DEPTH_LOG2-1:0] idx;
  lane_t mem [2**DEPTH_LOG2];

  // Truncate or zero extend to the array depth
  assign idx = DEPTH_LOG2'(bank_addr);

  always_ff @(posedge clk_1) begin
    if (en) begin
      if (wen) begin
        mem[idx] <= wdata;
      end
      // Old byte on a write
      rdata <= mem[idx];
    end
  end

endmodule

`default_nettype wire

// ==== verilog/load_rotator.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module load_rotator import mem_if_pkg::*; (
  input  logic      clk_1,
  input  logic      rst_n_sync,
  input  logic      accept,
  input  logic      is_load,
  input  lane_sel_t offset,
  input  lane_t     lane_data [`NUM_LANES],
  input  logic      resp_ready,
  output logic      resp_valid,
  output word_t     rdata,
  output logic      ready
);

  lane_sel_t offset_q;

  // Free when nothing is pending or the pending word leaves now
  assign ready = !resp_valid || resp_ready;

  always_ff @(posedge clk_1 or negedge rst_n_sync) begin
    if (!rst_n_sync) begin
      resp_valid <= 1'b0;
    end else if (accept && is_load) begin
      resp_valid <= 1'b1;
    end else if (resp_ready) begin
      resp_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_1) begin
    if (accept && is_load) begin
      offset_q <= offset;
    end
  end

  // Byte k comes from lane offset + k
  for (genvar k = 0; k < `NUM_LANES; k++) begin : g_byte
    assign rdata[k*`LANE_W +: `LANE_W] = lane_data[lane_sel_t'(offset_q + lane_sel_t'(k))];
  end

  // Banks hold their outputs while the response waits
  a_resp_held : assert property (
    @(posedge clk_1) disable iff (!rst_n_sync)
    resp_valid && !resp_ready |=> resp_valid && $stable(rdata)
  );

endmodule

`default_nettype wire

// ==== verilog/mem_port.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_port import mem_if_pkg::*; (
  input  logic        clk_1,
  input  logic        rst_n_sync,
  input  logic        req_valid,
  output logic        req_ready,
  input  addr_t       req_addr,
  input  word_t       req_wdata,
  input  store_ctrl_t req_store,
  output logic        resp_valid,
  input  logic        resp_ready,
  output word_t       resp_rdata
);

  logic  accept;
  logic  is_load;
  lane_t lane_data [`NUM_LANES];

  bank_if banks ();

  assign accept  = req_valid && req_ready;
  assign is_load = (req_store == ST_LOAD);

  lane_steer lane_steer_i (
    .addr   (req_addr),
    .wdata  (req_wdata),
    .store  (req_store),
    .accept (accept),
    .banks  (banks)
  );

  for (genvar i = 0; i < `NUM_LANES; i++) begin : g_bank
    byte_bank #(
      .DEPTH_LOG2 (`BANK_AW)
    ) bank_i (
      .clk_1     (clk_1),
      .en        (banks.en),
      .wen       (banks.wen[i]),
      .bank_addr (banks.bank_addr[i]),
      .wdata     (banks.wdata[i]),
      .rdata     (lane_data[i])
    );
  end

  load_rotator load_rotator_i (
    .clk_1      (clk_1),
    .rst_n_sync (rst_n_sync),
    .accept     (accept),
    .is_load    (is_load),
    .offset     (lane_sel_t'(req_addr)),
    .lane_data  (lane_data),
    .resp_ready (resp_ready),
    .resp_valid (resp_valid),
    .rdata      (resp_rdata),
    .ready      (req_ready)
  );

  // Stalled request must not change under the port
  a_req_stable : assert property (
    @(posedge clk_1) disable iff (!rst_n_sync)
    req_valid && !req_ready |=>
      $stable(req_addr) && $stable(req_wdata) && $stable(req_store)
  );

  // Banks are written only by an accepted request
  a_wen_accept : assert property (
    @(posedge clk_1) disable iff (!rst_n_sync)
    |banks.wen |-> req_valid && req_ready
  );

endmodule

`default_nettype wire

// ==== verilog/mem_interface.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_interface import mem_if_pkg::*; (
  input  logic        clk_1,
  input  logic        rst_n_sync,

  // Instruction port
  input  logic        imem_req_valid,
  output logic        imem_req_ready,
  input  addr_t       imem_req_addr,
  input  word_t       imem_req_wdata,
  input  store_ctrl_t imem_req_store,
  output logic        imem_resp_valid,
  input  logic        imem_resp_ready,
  output word_t       imem_resp_rdata,

  // Data port
  input  logic        dmem_req_valid,
  output logic        dmem_req_ready,
  input  addr_t       dmem_req_addr,
  input  word_t       dmem_req_wdata,
  input  store_ctrl_t dmem_req_store,
  output logic        dmem_resp_valid,
  input  logic        dmem_resp_ready,
  output word_t       dmem_resp_rdata
);

  // Separate storage per port
  mem_port imem_port_i (
    .clk_1      (clk_1),
    .rst_n_sync (rst_n_sync),
    .req_valid  (imem_req_valid),
    .req_ready  (imem_req_ready),
    .req_addr   (imem_req_addr),
    .req_wdata  (imem_req_wdata),
    .req_store  (imem_req_store),
    .resp_valid (imem_resp_valid),
    .resp_ready (imem_resp_ready),
    .resp_rdata (imem_resp_rdata)
  );

  mem_port dmem_port_i (
    .clk_1      (clk_1),
    .rst_n_sync (rst_n_sync),
    .req_valid  (dmem_req_valid),
    .req_ready  (dmem_req_ready),
    .req_addr   (dmem_req_addr),
    .req_wdata  (dmem_req_wdata),
    .req_store  (dmem_req_store),
    .resp_valid (dmem_resp_valid),
    .resp_ready (dmem_resp_ready),
    .resp_rdata (dmem_resp_rdata)
  );

endmodule

`default_nettype wire

// ==== verification/mem_interface_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mem_consts.svh"

module mem_interface_tb import mem_if_pkg::*; ();

  localparam int MEM_BYTES      = `NUM_LANES << `BANK_AW;
  localparam int FILL_LO_WORDS  = 80;
  localparam int FILL_HI_WORDS  = 4;
  localparam int DIRECTED_REQS  = 28;
  localparam int RAND_REQS      = 200;
  localparam int PORT_REQS      = FILL_LO_WORDS + FILL_HI_WORDS + DIRECTED_REQS + RAND_REQS;
  localparam int TIMEOUT_CYCLES = 4 * 2 * PORT_REQS + 200;

  typedef struct packed {
    addr_t       addr;
    word_t       wdata;
    store_ctrl_t store;
  } req_t;

  logic        clk_1;
  logic        rst_n_sync;
  logic [1:0]  req_valid;
  logic [1:0]  req_ready;
  addr_t       req_addr  [2];
  word_t       req_wdata [2];
  store_ctrl_t req_store [2];
  logic [1:0]  resp_valid;
  logic [1:0]  resp_ready;
  word_t       resp_rdata [2];

  // Shadow memory per port with imem at index 0
  logic [7:0]  shadow [2][MEM_BYTES];
  req_t        imem_req_q [$];
  req_t        dmem_req_q [$];
  word_t       imem_exp_q [$];
  word_t       dmem_exp_q [$];
  int          resp_cnt [2] = '{0, 0};
  logic [15:0] lfsr_state;
  int          data_errs  = 0;
  int          proto_errs = 0;
  int          seq_errs   = 0;
  int          cycles;

  mem_interface dut_i (
    .clk_1           (clk_1),
    .rst_n_sync      (rst_n_sync),
    .imem_req_valid  (req_valid[0]),
    .imem_req_ready  (req_ready[0]),
    .imem_req_addr   (req_addr[0]),
    .imem_req_wdata  (req_wdata[0]),
    .imem_req_store  (req_store[0]),
    .imem_resp_valid (resp_valid[0]),
    .imem_resp_ready (resp_ready[0]),
    .imem_resp_rdata (resp_rdata[0]),
    .dmem_req_valid  (req_valid[1]),
    .dmem_req_ready  (req_ready[1]),
    .dmem_req_addr   (req_addr[1]),
    .dmem_req_wdata  (req_wdata[1]),
    .dmem_req_store  (req_store[1]),
    .dmem_resp_valid (resp_valid[1]),
    .dmem_resp_ready (resp_ready[1]),
    .dmem_resp_rdata (resp_rdata[1])
  );

  initial begin
    clk_1 = 1'b0;
    forever begin
      #5 clk_1 = ~clk_1;
    end
  end

  // Galois form with taps for x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
    return bits;
  endfunction

  function automatic string port_name(input int p);
    return (p == 0) ? "imem" : "dmem";
  endfunction

  function automatic int wrap_idx(input addr_t a, input int k);
    return int'((a + addr_t'(k)) % MEM_BYTES);
  endfunction

  function automatic word_t fill_pattern(input int p, input addr_t a);
    return (a * 32'h9E37_79B1) ^ ((p == 0) ? 32'h0000_A5A5 : 32'h5A5A_0000);
  endfunction

  // Little-endian word starting at any byte address
  function automatic word_t ref_load(input int p, input addr_t a);
    word_t w;
    for (int k = 0; k < 4; k++) begin
      w[k*8 +: 8] = shadow[p][wrap_idx(a, k)];
    end
    return w;
  endfunction

  task automatic apply_store(input int p, input addr_t a, input word_t d, input store_ctrl_t s);
    int n;
    case (s)
      ST_BYTE: n = 1;
      ST_HALF: n = 2;
      ST_WORD: n = 4;
      default: n = 0;
    endcase
    for (int k = 0; k < n; k++) begin
      shadow[p][wrap_idx(a, k)] = d[k*8 +: 8];
    end
  endtask

  task automatic queue_req(input int p, input addr_t a, input word_t d, input store_ctrl_t s);
    req_t r;
    r.addr  = a;
    r.wdata = d;
    r.store = s;
    if (p == 0) begin
      imem_req_q.push_back(r);
    end else begin
      dmem_req_q.push_back(r);
    end
  endtask

  // Request taken at this edge, so the shadow moves on
  task automatic accept_req(input int p);
    req_t r;
    if (p == 0) begin
      r = imem_req_q.pop_front();
    end else begin
      r = dmem_req_q.pop_front();
    end
    if (r.store != ST_LOAD) begin
      apply_store(p, r.addr, r.wdata, r.store);
    end else if (p == 0) begin
      imem_exp_q.push_back(ref_load(p, r.addr));
    end else begin
      dmem_exp_q.push_back(ref_load(p, r.addr));
    end
  endtask

  task automatic drive_port(input int p, input logic bp, input logic taken);
    req_t r;
    int   pending;
    logic gap;
    pending = (p == 0) ? imem_req_q.size() : dmem_req_q.size();
    gap = 1'b0;
    if (bp) begin
      gap = (take_bits(2) == 0);
    end
    // A stalled request stays on the bus unchanged
    if (!req_valid[p] || taken) begin
      if (pending != 0 && !gap) begin
        r = (p == 0) ? imem_req_q[0] : dmem_req_q[0];
        req_valid[p] = 1'b1;
        req_addr[p]  = r.addr;
        req_wdata[p] = r.wdata;
        req_store[p] = r.store;
      end else begin
        req_valid[p] = 1'b0;
      end
    end
    resp_ready[p] = 1'b1;
    if (bp) begin
      resp_ready[p] = (take_bits(2) != 0);
    end
  endtask

  task automatic run_traffic(input logic bp);
    logic [1:0] taken;
    logic       done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk_1);
      for (int p = 0; p < 2; p++) begin
        taken[p] = req_valid[p] && req_ready[p];
        if (taken[p]) begin
          accept_req(p);
        end
      end
      #1;
      for (int p = 0; p < 2; p++) begin
        drive_port(p, bp, taken[p]);
      end
      done = imem_req_q.size() == 0 && dmem_req_q.size() == 0 && req_valid == 2'b00 &&
             resp_valid == 2'b00 && resp_cnt[0] == imem_exp_q.size() &&
             resp_cnt[1] == dmem_exp_q.size();
    end
  endtask

  task automatic directed_tests(input int p);
    word_t tag;
    tag = (p == 0) ? 32'h1100_0000 : 32'h2200_0000;
    for (int i = 0; i < 4; i++) begin
      queue_req(p, addr_t'(80 + 4 * i), tag ^ (32'h0BAD_F00D + i), ST_WORD);
    end
    for (int i = 0; i < 4; i++) begin
      queue_req(p, addr_t'(80 + 4 * i), '0, ST_LOAD);
    end
    // Bytes and halves at every offset with the half at 139 spilling into 140
    for (int i = 0; i < 4; i++) begin
      queue_req(p, addr_t'(128 + i), tag | (32'h11 * (i + 1)), ST_BYTE);
      queue_req(p, addr_t'(136 + i), tag ^ (32'hC0DE + 32'h1111 * i), ST_HALF);
    end
    queue_req(p, addr_t'(128), '0, ST_LOAD);
    queue_req(p, addr_t'(136), '0, ST_LOAD);
    queue_req(p, addr_t'(140), '0, ST_LOAD);
    // Unaligned words where the last one wraps to byte 0
    queue_req(p, addr_t'(145), tag ^ 32'h0123_4567, ST_WORD);
    queue_req(p, addr_t'(150), tag ^ 32'h89AB_CDEF, ST_WORD);
    queue_req(p, addr_t'(4094), tag ^ 32'h5EED_0BAD, ST_WORD);
    queue_req(p, addr_t'(145), '0, ST_LOAD);
    queue_req(p, addr_t'(150), '0, ST_LOAD);
    queue_req(p, addr_t'(4094), '0, ST_LOAD);
    queue_req(p, addr_t'(0), '0, ST_LOAD);
    queue_req(p, addr_t'(4092), '0, ST_LOAD);
    queue_req(p, addr_t'(148), '0, ST_LOAD);
  endtask

  task automatic random_mix(input int p, input int count);
    logic [2:0]  op;
    addr_t       a;
    word_t       d;
    store_ctrl_t s;
    for (int i = 0; i < count; i++) begin
      op = 3'(take_bits(3));
      a  = addr_t'(take_bits(8));
      d  = take_bits(32);
      case (op)
        3'd4:       s = ST_BYTE;
        3'd5:       s = ST_HALF;
        3'd6, 3'd7: s = ST_WORD;
        default:    s = ST_LOAD;
      endcase
      queue_req(p, a, d, s);
    end
  endtask

  task automatic check_resp(input int p);
    word_t want;
    int    depth;
    depth = (p == 0) ? imem_exp_q.size() : dmem_exp_q.size();
    if (resp_cnt[p] >= depth) begin
      $display("%0t: %s port returned a response with no load outstanding",
               $time, port_name(p));
      proto_errs++;
    end else begin
      want = (p == 0) ? imem_exp_q[resp_cnt[p]] : dmem_exp_q[resp_cnt[p]];
      if (resp_rdata[p] !== want) begin
        $display("Fail %0t: %s port load %0d returned %h, expected %h",
                 $time, port_name(p), resp_cnt[p], resp_rdata[p], want);
        data_errs++;
      end
      resp_cnt[p]++;
    end
  endtask

  // Response check in order per port
  always @(posedge clk_1) begin
    if (rst_n_sync) begin
      if (resp_valid[0] && resp_ready[0]) begin
        check_resp(0);
      end
      if (resp_valid[1] && resp_ready[1]) begin
        check_resp(1);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < TIMEOUT_CYCLES) begin
      @(posedge clk_1);
      cycles++;
    end
    $display("Timeout: traffic still pending after %0d cycles", TIMEOUT_CYCLES);
    $display("Errors: %0d data, %0d protocol, %0d sequence", data_errs, proto_errs, seq_errs);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    addr_t a;
    req_valid  = '0;
    resp_ready = '0;
    for (int p = 0; p < 2; p++) begin
      req_addr[p]  = '0;
      req_wdata[p] = '0;
      req_store[p] = ST_LOAD;
    end
    lfsr_state = 16'd25385;
    rst_n_sync = 1'b0;
    repeat (2) @(posedge clk_1);
    #1;
    rst_n_sync = 1'b1;

    for (int p = 0; p < 2; p++) begin
      if (resp_valid[p] !== 1'b0 || req_ready[p] !== 1'b1) begin
        $display("Fail %0t: %s port after reset resp_valid=%b req_ready=%b",
                 $time, port_name(p), resp_valid[p], req_ready[p]);
        seq_errs++;
      end
    end

    // Fill the low region and the top words
    for (int p = 0; p < 2; p++) begin
      for (int w = 0; w < FILL_LO_WORDS; w++) begin
        a = addr_t'(4 * w);
        queue_req(p, a, fill_pattern(p, a), ST_WORD);
      end
      for (int w = 0; w < FILL_HI_WORDS; w++) begin
        a = addr_t'(MEM_BYTES - 4 * FILL_HI_WORDS + 4 * w);
        queue_req(p, a, fill_pattern(p, a), ST_WORD);
      end
    end
    run_traffic(1'b0);

    for (int p = 0; p < 2; p++) begin
      directed_tests(p);
    end
    run_traffic(1'b0);

    for (int p = 0; p < 2; p++) begin
      random_mix(p, RAND_REQS);
    end
    run_traffic(1'b1);

    $display("Errors: %0d data, %0d protocol, %0d sequence", data_errs, proto_errs, seq_errs);
    if (data_errs + proto_errs + seq_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_interface.f ====
+incdir+verilog
verilog/mem_if_pkg.sv
verilog/bank_if.sv
verilog/lane_steer.sv
verilog/byte_bank.sv
verilog/load_rotator.sv
verilog/mem_port.sv
verilog/mem_interface.sv
verification/mem_interface_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mem_interface_tb -f mem_interface.f -o mem_interface_sim

out=$(./obj_dir/mem_interface_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '\*\* PASS \*\*'; then
  exit 0
fi
exit 1
